/* logic/aux_pd_config.svh */
`ifndef AUX_PD_CONFIG_SVH
`define AUX_PD_CONFIG_SVH

`default_nettype none

// sample width of each ADC lane
`define AUX_PD_NADC 8

// lanes per parallel data clock
`define AUX_PD_NTI 4

// window counter width, 2**6 cycles per window
`define AUX_PD_NCNTR 6

// settle span width, accumulate from counter 2**3-1 on
`define AUX_PD_NSETTLE 3

`define AUX_PD_NFR 1        // fraction bits of the offset register
`define AUX_PD_DY0 1        // threshold widening step

`default_nettype wire

`endif

/* logic/aux_pd_pkg.sv */
`include "aux_pd_config.svh"
`default_nettype none

package aux_pd_pkg;

    // signed ADC sample, one lane
    typedef logic signed [`AUX_PD_NADC-1:0] sample_t;

    // magnitude of a sample, -128 maps to 128
    typedef logic [`AUX_PD_NADC-1:0] mag_t;

    typedef logic [$clog2(2*`AUX_PD_NTI)-1:0] lane_cnt_t;   // errors in one cycle

    // window error total, room for every lane of every cycle
    typedef logic [`AUX_PD_NADC+`AUX_PD_NCNTR+$clog2(2*`AUX_PD_NTI)-1:0] err_cnt_t;

    typedef enum logic {
        SEARCH_STARTUP,     // first window, record only
        SEARCH_TRACK        // hill climbing
    } search_state_e;

    typedef enum logic [1:0] {
        STEP_REVERSE,       // errors rose
        STEP_WIDEN,         // window had no errors
        STEP_ADVANCE        // errors fell or held
    } step_op_e;

endpackage

`default_nettype wire

/* logic/pd_sample_decode.sv */
`include "aux_pd_config.svh"
`default_nettype none

module pd_sample_decode (
    input  wire aux_pd_pkg::sample_t din [`AUX_PD_NTI],   // one sample per lane
    input  wire aux_pd_pkg::mag_t    threshold,           // error boundary around zero
    input  wire aux_pd_pkg::mag_t    acc_min,             // running minimum so far
    output aux_pd_pkg::lane_cnt_t    lane_err_inc,
    output aux_pd_pkg::mag_t         lane_min
);

    import aux_pd_pkg::*;

    localparam int nadc = `AUX_PD_NADC;
    localparam int nti  = `AUX_PD_NTI;

    mag_t lane_mag [nti];

    // two's complement magnitude per lane
    genvar k;
    generate
        for (k = 0; k < nti; k++) begin : gen_mag
            assign lane_mag[k] = din[k][nadc-1] ? mag_t'(-din[k]) : mag_t'(din[k]);
        end
    endgenerate

    // samples close to the slicer zero count as errors
    always_comb begin
        lane_err_inc = '0;
        for (int i = 0; i < nti; i++) begin
            if (lane_mag[i] < threshold) begin
                lane_err_inc = lane_err_inc + lane_cnt_t'(1);
            end
        end
    end

    // fold this cycle's lanes into the running minimum
    always_comb begin
        lane_min = acc_min;
        for (int i = 0; i < nti; i++) begin
            if (lane_mag[i] < lane_min) begin
                lane_min = lane_mag[i];     // new smallest
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pd_window_accum.sv */
`include "aux_pd_config.svh"
`default_nettype none

module pd_window_accum (
    input  wire logic                  clk,
    input  wire logic                  enable,        // async clear, active low
    input  wire aux_pd_pkg::lane_cnt_t lane_err_inc,  // this cycle's errors
    input  wire aux_pd_pkg::mag_t      lane_min,      // minimum incl. this cycle
    output logic                       window_end,
    output aux_pd_pkg::err_cnt_t       win_err_cnt,
    output aux_pd_pkg::mag_t           acc_min
);

    import aux_pd_pkg::*;

    localparam int ncntr   = `AUX_PD_NCNTR;
    localparam int nsettle = `AUX_PD_NSETTLE;

    // first count that accumulates, after the settle span
    localparam logic [ncntr-1:0] settle_cnt = ncntr'((1 << nsettle) - 1);
    localparam logic [ncntr-1:0] clear_cnt  = '0;
    localparam logic [ncntr-1:0] first_cnt  = ncntr'(1);

    logic [ncntr-1:0] cntr;     // free running window counter
    logic             acc_active;

    assign window_end = (cntr == '1);
    assign acc_active = (cntr >= settle_cnt);

    always_ff @(posedge clk or negedge enable) begin
        if (!enable) begin
            cntr <= '0;
        end else begin
            cntr <= cntr + first_cnt;   // wraps at window end
        end
    end

    // error total and minimum over one window
    always_ff @(posedge clk or negedge enable) begin
        if (!enable) begin
            win_err_cnt <= '1;
            acc_min     <= '1;          // largest magnitude
        end else if (cntr == clear_cnt) begin
            win_err_cnt <= '0;
            acc_min     <= '1;
        end else if (acc_active) begin
            win_err_cnt <= win_err_cnt + err_cnt_t'(lane_err_inc);
            acc_min     <= lane_min;
        end
    end

    // the total only grows once the window has been cleared
    property err_cnt_monotonic;
        @(posedge clk) disable iff (!enable)
            (cntr > first_cnt) |-> (win_err_cnt >= $past(win_err_cnt));
    endproperty

    assert property (err_cnt_monotonic)
        else $error("window error total decreased inside a window");

endmodule

`default_nettype wire

/* logic/pd_offset_search.sv */
`include "aux_pd_config.svh"
`default_nettype none

module pd_offset_search (
    input  wire logic                 clk,
    input  wire logic                 enable,         // async load of external offset
    input  wire aux_pd_pkg::sample_t  pd_offset_ext,
    input  wire logic                 window_end,
    input  wire aux_pd_pkg::err_cnt_t win_err_cnt,
    input  wire aux_pd_pkg::mag_t     win_min,
    output aux_pd_pkg::mag_t          threshold,
    output aux_pd_pkg::sample_t       pd_offset
);

    import aux_pd_pkg::*;

    localparam int nadc = `AUX_PD_NADC;
    localparam int nfr  = `AUX_PD_NFR;

    typedef logic signed [nadc+nfr-1:0] offset_fp_t;

    localparam mag_t       dy0      = mag_t'(`AUX_PD_DY0);
    localparam offset_fp_t step_one = offset_fp_t'(1);
    localparam offset_fp_t step_two = offset_fp_t'(2);

    search_state_e state;
    step_op_e      step_op;
    logic          dir;         // 1 moves the offset up
    err_cnt_t      err_prev;
    mag_t          min_prev;
    mag_t          dy;
    offset_fp_t    offset_fp;   // offset with fraction bits
    offset_fp_t    step_fp;

    assign threshold = min_prev + dy;
    assign pd_offset = offset_fp[nadc+nfr-1 -: nadc];   // integer part

    // compare this window against the last one
    always_comb begin
        if (win_err_cnt > err_prev) begin
            step_op = STEP_REVERSE;
        end else if (win_err_cnt == '0) begin
            step_op = STEP_WIDEN;
        end else begin
            step_op = STEP_ADVANCE;
        end
    end

    // signed step in fixed point units
    always_comb begin
        case (step_op)
            STEP_REVERSE: step_fp = dir ? -step_one : step_one;    // back off
            STEP_WIDEN:   step_fp = dir ? step_one : -step_one;
            default:      step_fp = dir ? step_two : -step_two;
        endcase
    end

    always_ff @(posedge clk or negedge enable) begin
        if (!enable) begin
            state     <= SEARCH_STARTUP;
            dir       <= 1'b1;
            err_prev  <= '0;
            min_prev  <= '1;
            dy        <= dy0;
            offset_fp <= offset_fp_t'(pd_offset_ext) <<< nfr;
        end else if (window_end) begin
            if (state == SEARCH_STARTUP) begin
                // nothing to compare against yet
                state    <= SEARCH_TRACK;
                err_prev <= win_err_cnt;
                min_prev <= win_min;
            end else begin
                offset_fp <= offset_fp + step_fp;
                case (step_op)
                    STEP_REVERSE: begin
                        dir      <= ~dir;
                        dy       <= dy0;
                        err_prev <= win_err_cnt;
                        min_prev <= win_min;
                    end
                    STEP_WIDEN: begin
                        dy       <= dy + dy0;   // open the threshold
                        err_prev <= '1;         // next window never reverses
                    end
                    default: begin
                        err_prev <= win_err_cnt;
                    end
                endcase
            end
        end
    end

    // offset moves only at a window boundary, by one or two units
    property offset_step_on_window_end;
        @(posedge clk) disable iff (!enable)
            ($past(enable) && (offset_fp != $past(offset_fp))) |->
                ($past(window_end) &&
                 (offset_fp_t'(offset_fp - $past(offset_fp)) inside {-2, -1, 1, 2}));
    endproperty

    assert property (offset_step_on_window_end)
        else $error("offset changed outside a window end or by more than 2");

endmodule

`default_nettype wire

/* logic/aux_pd_top.sv */
`include "aux_pd_config.svh"
`default_nettype none

module aux_pd_top (
    input  wire logic                clk,               // parallel data clock
    input  wire logic                enable,            // low loads pd_offset_ext
    input  wire aux_pd_pkg::sample_t din [`AUX_PD_NTI],
    input  wire aux_pd_pkg::sample_t pd_offset_ext,
    output aux_pd_pkg::sample_t      pd_offset
);

    import aux_pd_pkg::*;

    lane_cnt_t lane_err_inc;
    mag_t      lane_min;
    mag_t      acc_min;         // also the window minimum
    mag_t      threshold;
    logic      window_end;
    err_cnt_t  win_err_cnt;

    pd_sample_decode pd_sample_decode_inst (
        .din          (din),
        .threshold    (threshold),
        .acc_min      (acc_min),
        .lane_err_inc (lane_err_inc),
        .lane_min     (lane_min)
    );

    pd_window_accum pd_window_accum_inst (
        .clk          (clk),
        .enable       (enable),
        .lane_err_inc (lane_err_inc),
        .lane_min     (lane_min),
        .window_end   (window_end),
        .win_err_cnt  (win_err_cnt),
        .acc_min      (acc_min)
    );

    pd_offset_search pd_offset_search_inst (
        .clk           (clk),
        .enable        (enable),
        .pd_offset_ext (pd_offset_ext),
        .window_end    (window_end),
        .win_err_cnt   (win_err_cnt),
        .win_min       (acc_min),
        .threshold     (threshold),
        .pd_offset     (pd_offset)
    );

endmodule

`default_nettype wire

/* verif/aux_pd_checker.sv */
`include "aux_pd_config.svh"
`default_nettype none

module aux_pd_checker (
    input  wire logic                clk,
    input  wire logic                enable,
    input  wire aux_pd_pkg::sample_t din [`AUX_PD_NTI],
    input  wire aux_pd_pkg::sample_t pd_offset_ext,
    input  wire aux_pd_pkg::sample_t pd_offset,
    output int                       error_count,
    output int                       check_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import aux_pd_pkg::*;

    localparam int nti          = `AUX_PD_NTI;
    localparam int nfr          = `AUX_PD_NFR;
    localparam int dy0          = `AUX_PD_DY0;
    localparam int mag_max      = (1 << `AUX_PD_NADC) - 1;
    localparam int win_last     = (1 << `AUX_PD_NCNTR) - 1;
    localparam int settle_first = (1 << `AUX_PD_NSETTLE) - 1;
    localparam int err_bits     = `AUX_PD_NADC + `AUX_PD_NCNTR + $clog2(2 * nti);
    localparam int err_ones     = (1 << err_bits) - 1;

    int    errors = 0;
    int    checks = 0;
    int    m_cnt = 0;           // window counter
    int    m_tot = err_ones;    // error total
    int    m_amin = mag_max;    // running minimum
    int    m_err_prev = 0;
    int    m_min_prev = mag_max;
    int    m_dy = dy0;
    int    m_off_fp = 0;        // offset in fixed point units
    bit    m_dir = 1'b1;        // up
    bit    m_tracking = 1'b0;
    bit    m_moved = 1'b0;      // last edge changed the offset
    bit    was_enabled = 1'b0;
    string test_name;

    assign error_count = errors;
    assign check_count = checks;

    function automatic int magnitude(input sample_t s);
        return (s < 0) ? -int'(s) : int'(s);
    endfunction

    // state right after enable goes low
    task automatic load_model();
        m_cnt      = 0;
        m_tot      = err_ones;
        m_amin     = mag_max;
        m_err_prev = 0;
        m_min_prev = mag_max;
        m_dy       = dy0;
        m_dir      = 1'b1;
        m_tracking = 1'b0;
        m_moved    = 1'b0;
        m_off_fp   = int'(pd_offset_ext) * (1 << nfr);
    endtask

    // advance the model across one rising edge
    task automatic step_model();
        int thr;
        int inc;
        int lmin;
        int mag;
        int n_tot;
        int n_amin;
        thr  = (m_min_prev + m_dy) % (mag_max + 1);    // 8 bit wrap
        inc  = 0;
        lmin = m_amin;
        for (int i = 0; i < nti; i++) begin
            mag = magnitude(din[i]);
            if (mag < thr) inc++;
            if (mag < lmin) lmin = mag;
        end
        n_tot  = m_tot;
        n_amin = m_amin;
        if (m_cnt == 0) begin
            n_tot  = 0;
            n_amin = mag_max;
        end else if (m_cnt >= settle_first) begin
            n_tot  = m_tot + inc;
            n_amin = lmin;
        end
        m_moved = 1'b0;
        if (m_cnt == win_last) begin
            if (!m_tracking) begin
                m_tracking = 1'b1;      // first window only records
                m_err_prev = m_tot;
                m_min_prev = m_amin;
            end else if (m_tot > m_err_prev) begin
                m_off_fp   = m_off_fp + (m_dir ? -1 : 1);
                m_dir      = !m_dir;
                m_dy       = dy0;
                m_err_prev = m_tot;
                m_min_prev = m_amin;
                m_moved    = 1'b1;
            end else if (m_tot == 0) begin
                m_off_fp   = m_off_fp + (m_dir ? 1 : -1);
                m_dy       = (m_dy + dy0) % (mag_max + 1);
                m_err_prev = err_ones;
                m_moved    = 1'b1;
            end else begin
                m_off_fp   = m_off_fp + (m_dir ? 2 : -2);
                m_err_prev = m_tot;
                m_moved    = 1'b1;
            end
        end
        m_tot  = n_tot;
        m_amin = n_amin;
        m_cnt  = (m_cnt + 1) % (win_last + 1);
    endtask

    task automatic compare_offset(input string name);
        sample_t expected;
        expected = sample_t'(m_off_fp >>> nfr);     // integer part
        checks++;
        if (pd_offset !== expected) begin
            errors++;
            $display("error %s: expected %0d actual %0d at %0t",
                     name, expected, pd_offset, $time);
        end
    endtask

    // inputs and outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!enable) begin
            load_model();
            test_name = was_enabled ? "reload" : "hold";
            compare_offset(test_name);
        end else begin
            if (!m_tracking) test_name = "startup";
            else if (m_moved) test_name = "step";
            else test_name = "stable";
            compare_offset(test_name);
            was_enabled = 1'b1;
            step_model();
        end
    end

endmodule

`default_nettype wire

/* verif/tb_aux_pd.sv */
`include "aux_pd_config.svh"
`default_nettype none

module tb_aux_pd;

    timeunit 1ns;
    timeprecision 100ps;

    import aux_pd_pkg::*;

    localparam int nti            = `AUX_PD_NTI;
    localparam int win_cycles     = 1 << `AUX_PD_NCNTR;
    localparam int run_windows    = 40;
    localparam int timeout_cycles = run_windows * win_cycles + 440;
    localparam int half_period    = 20;
    localparam int drive_delay    = 2;

    logic        clk = 1'b0;    // low before time 0, so no edge at start
    logic        enable;
    sample_t     din [nti];
    sample_t     pd_offset_ext;
    sample_t     pd_offset;
    int          error_count;
    int          check_count;
    logic [31:0] rng_state = 32'd56;
    int          run_cycle = 0;
    int          cycle_count = 0;

    // magnitude ranges, switched every two windows
    int mag_lo [4] = '{20, 0, 50, 10};
    int mag_hi [4] = '{90, 60, 120, 40};

    initial begin
        forever #half_period clk = ~clk;
    end

    aux_pd_top aux_pd_top_inst (
        .clk           (clk),
        .enable        (enable),
        .din           (din),
        .pd_offset_ext (pd_offset_ext),
        .pd_offset     (pd_offset)
    );

    aux_pd_checker aux_pd_checker_inst (
        .clk           (clk),
        .enable        (enable),
        .din           (din),
        .pd_offset_ext (pd_offset_ext),
        .pd_offset     (pd_offset),
        .error_count   (error_count),
        .check_count   (check_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        rng_state = lcg_next(rng_state);
        return lo + int'({9'd0, rng_state[30:8]}) % (hi - lo + 1);   // upper bits only
    endfunction

    task automatic drive_samples();
        int sel;
        int mag;
        sel = (run_cycle / (2 * win_cycles)) % 4;
        for (int i = 0; i < nti; i++) begin
            mag = rand_range(mag_lo[sel], mag_hi[sel]);
            din[i] = (rand_range(0, 1) == 1) ? sample_t'(-mag) : sample_t'(mag);
        end
        run_cycle++;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #drive_delay;
            drive_samples();
        end
    endtask

    // new external offset one cycle ahead of the enable drop
    task automatic reload_offset(input int low_cycles);
        @(posedge clk);
        #drive_delay;
        pd_offset_ext = sample_t'(rand_range(-50, 50));
        @(posedge clk);
        #drive_delay;
        enable = 1'b0;
        repeat (low_cycles) @(posedge clk);
        #drive_delay;
        enable = 1'b1;
    endtask

    initial begin
        enable        = 1'b0;
        pd_offset_ext = sample_t'(rand_range(-50, 50));
        for (int i = 0; i < nti; i++) din[i] = '0;
        repeat (2) @(posedge clk);
        #drive_delay;
        enable = 1'b1;
        run_cycles(14 * win_cycles + 30);   // ends mid-window
        reload_offset(3);
        run_cycles(12 * win_cycles + 20);
        reload_offset(2);
        run_cycles(12 * win_cycles);
        @(posedge clk);
        @(negedge clk);
        #1;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // run length guard
    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* aux_pd.f */
+incdir+logic
logic/aux_pd_pkg.sv
logic/pd_sample_decode.sv
logic/pd_window_accum.sv
logic/pd_offset_search.sv
logic/aux_pd_top.sv
verif/aux_pd_checker.sv
verif/tb_aux_pd.sv

/* run_sim.sh */
#!/bin/sh
# build and run the aux_pd testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f aux_pd.f --top-module tb_aux_pd -o tb_aux_pd
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_aux_pd > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log"
    exit 1
fi
